// ==== profileUnit.f ====
hdl/profilePkg.sv
hdl/resetSequencer.sv
hdl/ciIssue.sv
hdl/profileCounterSlot.sv
hdl/ciCollect.sv
hdl/profileUnit.sv
test/profileUnit_chk.sv
test/profileUnit_tb.sv

// ==== Bender.yml ====
package:
  name: profileUnit

sources:
  - files:
      - hdl/profilePkg.sv
      - hdl/resetSequencer.sv
      - hdl/ciIssue.sv
      - hdl/profileCounterSlot.sv
      - hdl/ciCollect.sv
      - hdl/profileUnit.sv
  - target: test
    files:
      - test/profileUnit_chk.sv
      - test/profileUnit_tb.sv

// ==== test/profileUnit_tb.sv ====
`timescale 1ns/1ns

module profileUnit_tb;

  localparam int TimeoutCycles = 2000; // About four times the test length.

  logic                             s_systemClock;
  logic                             s_pllLocked;
  logic                             ciReq;
  profilePkg::ciRequest_t           ciRequest;
  profilePkg::profileEvents_t       events;
  logic                             ciAck;
  logic [profilePkg::DataWidth-1:0] ciResult;
  logic                             systemReady;

  int          dataErrors;
  int          flagErrors;
  int          cycleCount;
  logic [15:0] lfsrState;

  profileUnit u_profileUnit (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciReq        (ciReq),
    .ciRequest    (ciRequest),
    .events       (events),
    .ciAck        (ciAck),
    .ciResult     (ciResult),
    .systemReady  (systemReady)
  );

  always #2 s_systemClock = ~s_systemClock;

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles.", TimeoutCycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic nextRandomBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
      lfsrState = lfsrState ^ 16'hB400; // Galois taps 16, 14, 13, 11.
    end
    return outBit;
  endfunction

  function automatic logic [profilePkg::DataWidth-1:0] randomBits(input int count);
    logic [profilePkg::DataWidth-1:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[profilePkg::DataWidth-2:0], nextRandomBit()};
    end
    return value;
  endfunction

  function automatic logic [profilePkg::DataWidth-1:0] commandWord(
    input logic clear, input logic enable, input logic disableCounting
  );
    logic [profilePkg::DataWidth-1:0] word;
    word = '0;
    word[profilePkg::CmdClearBit] = clear;
    word[profilePkg::CmdEnableBit] = enable;
    word[profilePkg::CmdDisableBit] = disableCounting;
    return word;
  endfunction

  function automatic profilePkg::ciRequest_t buildRequest(
    input int id, input logic [profilePkg::DataWidth-1:0] valueA,
    input logic [profilePkg::DataWidth-1:0] valueB
  );
    profilePkg::ciRequest_t request;
    request.id = profilePkg::IdWidth'(id);
    request.valueA = valueA;
    request.valueB = valueB;
    return request;
  endfunction

  task automatic checkData(input logic [profilePkg::DataWidth-1:0] actual,
                           input logic [profilePkg::DataWidth-1:0] expected, input string what);
    if (actual !== expected) begin
      dataErrors++;
      $display("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      flagErrors++;
      $display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // Four-phase call. Entered and left 1 ns after a rising edge.
  task automatic ciCall(input profilePkg::ciRequest_t request, input int holdCycles,
                        output logic [profilePkg::DataWidth-1:0] result);
    int ackWait;
    ciRequest = request;
    ciReq = 1'b1;
    ackWait = 0;
    do begin
      @(posedge s_systemClock);
      #1;
      ackWait++;
    end while (!ciAck);
    checkFlag(ackWait == 2, 1'b1, "ciAck two edges after ciReq is sampled");
    result = ciResult;
    repeat (holdCycles) begin
      @(posedge s_systemClock);
      #1;
      checkFlag(ciAck, 1'b1, "ciAck held under back-pressure");
      checkData(ciResult, result, "ciResult held under back-pressure");
    end
    ciReq = 1'b0;
    @(posedge s_systemClock);
    #1;
    checkFlag(ciAck, 1'b0, "ciAck falls after ciReq drops");
  endtask

  task automatic readSlot(input int slot, output logic [profilePkg::DataWidth-1:0] result);
    ciCall(buildRequest(profilePkg::CounterBaseId + slot, '0, randomBits(32)), 0, result);
  endtask

  task automatic commandSlot(input int slot, input logic [profilePkg::DataWidth-1:0] command,
                             output logic [profilePkg::DataWidth-1:0] result);
    ciCall(buildRequest(profilePkg::CounterBaseId + slot, command, randomBits(32)), 0, result);
  endtask

  task automatic driveEvent(input int slot, input int cycles);
    logic [profilePkg::NumCounters-1:0] eventBits;
    eventBits = '0;
    eventBits[slot] = 1'b1;
    events = eventBits;
    repeat (cycles) @(posedge s_systemClock);
    #1;
    events = '0;
  endtask

  task automatic checkResetRelease();
    int readyCycles;
    repeat (3) begin
      @(posedge s_systemClock);
      #1;
      checkFlag(systemReady, 1'b0, "systemReady during reset");
      checkFlag(ciAck, 1'b0, "ciAck during reset");
    end
    s_pllLocked = 1'b1;
    readyCycles = 0;
    do begin
      @(posedge s_systemClock);
      #1;
      readyCycles++;
    end while (!systemReady);
    checkData(readyCycles, profilePkg::ResetCycles, "cycles from PLL lock to systemReady");
  endtask

  // Covers counting per slot and independence of the slots.
  task automatic checkCounting();
    logic [profilePkg::DataWidth-1:0] result;
    int                               count;
    for (int slot = 0; slot < profilePkg::NumCounters; slot++) begin
      for (int other = 0; other < profilePkg::NumCounters; other++) begin
        commandSlot(other, commandWord(1'b1, 1'b1, 1'b0), result);
      end
      count = int'(randomBits(4)) + 1;
      driveEvent(slot, count);
      for (int other = 0; other < profilePkg::NumCounters; other++) begin
        readSlot(other, result);
        checkData(result, (other == slot) ? count : 0,
                  $sformatf("slot %0d after events on bit %0d", other, slot));
      end
    end
  endtask

  task automatic checkDisable();
    logic [profilePkg::DataWidth-1:0] result;
    logic [profilePkg::DataWidth-1:0] atDisable;
    int                               count;
    for (int slot = 0; slot < profilePkg::NumCounters; slot++) begin
      commandSlot(slot, commandWord(1'b1, 1'b1, 1'b0), result);
      count = int'(randomBits(4)) + 1;
      driveEvent(slot, count);
      commandSlot(slot, commandWord(1'b0, 1'b0, 1'b1), atDisable);
      checkData(atDisable, count, $sformatf("slot %0d read at disable", slot));
      driveEvent(slot, int'(randomBits(4)) + 1);
      readSlot(slot, result);
      checkData(result, count, $sformatf("slot %0d frozen after disable", slot));
    end
  endtask

  task automatic checkUnclaimed();
    logic [profilePkg::DataWidth-1:0] result;
    int                               id;
    repeat (4) begin
      do begin
        id = int'(randomBits(profilePkg::IdWidth));
      end while (id >= profilePkg::CounterBaseId &&
                 id < profilePkg::CounterBaseId + profilePkg::NumCounters);
      ciCall(buildRequest(id, randomBits(32), randomBits(32)), 0, result);
      checkData(result, '0, $sformatf("unclaimed id %0d", id));
    end
  endtask

  task automatic checkBackPressure();
    logic [profilePkg::DataWidth-1:0] result;
    int                               slot;
    int                               count;
    repeat (3) begin
      slot = int'(randomBits(2));
      commandSlot(slot, commandWord(1'b1, 1'b1, 1'b0), result);
      count = int'(randomBits(4)) + 1;
      driveEvent(slot, count);
      ciCall(buildRequest(profilePkg::CounterBaseId + slot, '0, '0),
             int'(randomBits(3)) + 1, result);
      checkData(result, count, $sformatf("slot %0d read under back-pressure", slot));
      readSlot(slot, result);
      checkData(result, count, $sformatf("slot %0d read after back-pressure", slot));
    end
  endtask

  initial begin
    s_systemClock = 1'b0;
    s_pllLocked = 1'b0;
    ciReq = 1'b0;
    ciRequest = '0;
    events = '0;
    dataErrors = 0;
    flagErrors = 0;
    cycleCount = 0;
    lfsrState = 16'd67;
    checkResetRelease();
    checkCounting();
    checkDisable();
    checkUnclaimed();
    checkBackPressure();
    $display("Errors: %0d data, %0d flag", dataErrors, flagErrors);
    if (dataErrors == 0 && flagErrors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== test/profileUnit_chk.sv ====
`timescale 1ns/1ns

module profileUnitChk (
  input logic                             s_systemClock,
  input logic                             s_pllLocked,
  input logic                             ciReq,
  input logic                             ciAck,
  input logic [profilePkg::DataWidth-1:0] ciResult
);

  // The request was seen one edge before ciAck rose.
  property ackNeedsRequest;
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      $rose(ciAck) |-> $past(ciReq);
  endproperty

  property ackHeldWhileRequest;
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      ciAck && ciReq |=> ciAck;
  endproperty

  property resultStableDuringAck;
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      ciAck && $past(ciAck) |-> $stable(ciResult);
  endproperty

  assert property (ackNeedsRequest)
    else $error("ciAck rose while ciReq was low.");

  assert property (ackHeldWhileRequest)
    else $error("ciAck fell while ciReq was still high.");

  assert property (resultStableDuringAck)
    else $error("ciResult changed while ciAck was high.");

endmodule

bind ciCollect profileUnitChk u_profileUnitChk (
  .s_systemClock(s_systemClock),
  .s_pllLocked  (s_pllLocked),
  .ciReq        (ciReq),
  .ciAck        (ciAck),
  .ciResult     (ciResult)
);

// ==== hdl/profileUnit.sv ====
`timescale 1ns/1ns

module profileUnit (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             ciReq,
  input  profilePkg::ciRequest_t           ciRequest,
  input  profilePkg::profileEvents_t       events,
  output logic                             ciAck,
  output logic [profilePkg::DataWidth-1:0] ciResult,
  output logic                             systemReady
);

  logic                                 start;
  profilePkg::ciRequest_t               issued;
  profilePkg::ciResponse_t              responses [profilePkg::NumCounters];
  logic [profilePkg::NumCounters-1:0]   eventVector;

  assign eventVector = events;

  resetSequencer u_resetSequencer (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady)
  );

  ciIssue u_ciIssue (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady),
    .ciReq        (ciReq),
    .ciRequest    (ciRequest),
    .start        (start),
    .issued       (issued)
  );

  for (genvar i = 0; i < profilePkg::NumCounters; i++) begin : gSlot
    profileCounterSlot #(
      .SlotIndex(i)
    ) u_profileCounterSlot (
      .s_systemClock(s_systemClock),
      .s_pllLocked  (s_pllLocked),
      .systemReady  (systemReady),
      .start        (start),
      .countEvent   (eventVector[i]),
      .issued       (issued),
      .response     (responses[i])
    );
  end

  ciCollect u_ciCollect (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady),
    .ciReq        (ciReq),
    .start        (start),
    .responses    (responses),
    .ciAck        (ciAck),
    .ciResult     (ciResult)
  );

endmodule

// ==== hdl/ciCollect.sv ====
`timescale 1ns/1ns

module ciCollect (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             systemReady,
  input  logic                             ciReq,
  input  logic                             start,
  input  profilePkg::ciResponse_t          responses [profilePkg::NumCounters],
  output logic                             ciAck,
  output logic [profilePkg::DataWidth-1:0] ciResult
);

  profilePkg::ciResponse_t mergedResponse;

  // Wired-OR of all slot answers; idle slots drive zeros.
  always_comb begin
    mergedResponse = '0;
    for (int i = 0; i < profilePkg::NumCounters; i++) begin
      mergedResponse = profilePkg::ciResponse_t'(mergedResponse | responses[i]);
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciAck <= 1'b0;
    end else if (!systemReady) begin
      ciAck <= 1'b0;
    end else if (start) begin
      ciAck <= 1'b1; // Also for an unclaimed id.
    end else if (ciAck && !ciReq) begin
      ciAck <= 1'b0;
    end
  end

  // Held until the next start, so it is stable for the whole ack phase.
  always_ff @(posedge s_systemClock) begin
    if (start) begin
      ciResult <= mergedResponse.done ? mergedResponse.result : '0;
    end
  end

endmodule

// ==== hdl/profileCounterSlot.sv ====
`timescale 1ns/1ns

module profileCounterSlot #(
  parameter int SlotIndex = 0
) (
  input  logic                    s_systemClock,
  input  logic                    s_pllLocked,
  input  logic                    systemReady,
  input  logic                    start,
  input  logic                    countEvent,
  input  profilePkg::ciRequest_t  issued,
  output profilePkg::ciResponse_t response
);

  localparam logic [profilePkg::IdWidth-1:0] SlotId =
    profilePkg::IdWidth'(profilePkg::CounterBaseId + SlotIndex);

  logic [profilePkg::DataWidth-1:0] eventCount;
  logic                             countEnabled;
  logic                             hit;
  logic                             cmdEnable;
  logic                             cmdDisable;
  logic                             cmdClear;

  assign hit = start && (issued.id == SlotId);
  assign cmdEnable = issued.valueA[profilePkg::CmdEnableBit];
  assign cmdDisable = issued.valueA[profilePkg::CmdDisableBit];
  assign cmdClear = issued.valueA[profilePkg::CmdClearBit];

  // Answer with the count as it stood before this command.
  assign response.done = hit;
  assign response.result = hit ? eventCount : '0;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      eventCount <= '0;
      countEnabled <= 1'b0;
    end else if (!systemReady) begin
      eventCount <= '0;
      countEnabled <= 1'b0;
    end else begin
      if (hit && cmdClear) begin
        eventCount <= '0;
      end else if (countEnabled && countEvent) begin
        eventCount <= eventCount + 1'b1; // Wraps.
      end
      if (hit) begin
        if (cmdDisable) begin
          countEnabled <= 1'b0; // Disable wins.
        end else if (cmdEnable) begin
          countEnabled <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/ciIssue.sv ====
`timescale 1ns/1ns

module ciIssue (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  logic                   systemReady,
  input  logic                   ciReq,
  input  profilePkg::ciRequest_t ciRequest,
  output logic                   start,
  output profilePkg::ciRequest_t issued
);

  typedef enum logic {
    idleState,
    waitLowState
  } issueState_t;

  issueState_t issueState;
  logic        acceptRequest;

  assign acceptRequest = (issueState == idleState) && ciReq;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      issueState <= idleState;
      start <= 1'b0;
    end else if (!systemReady) begin
      issueState <= idleState;
      start <= 1'b0;
    end else begin
      start <= acceptRequest; // One cycle only.
      case (issueState)
        idleState: begin
          if (ciReq) begin
            issueState <= waitLowState;
          end
        end
        waitLowState: begin
          if (!ciReq) begin
            issueState <= idleState; // Host finished the handshake.
          end
        end
        default: issueState <= idleState;
      endcase
    end
  end

  // Slots see a stable id and operands during start.
  always_ff @(posedge s_systemClock) begin
    if (acceptRequest) begin
      issued <= ciRequest;
    end
  end

endmodule

// ==== hdl/resetSequencer.sv ====
`timescale 1ns/1ns

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady
);

  logic [profilePkg::ResetCountWidth-1:0] resetCount;

  localparam logic [profilePkg::ResetCountWidth-1:0] ReleaseCount =
    profilePkg::ResetCountWidth'(profilePkg::ResetCycles);

  // Holds at zero until the PLL locks, then saturates.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (resetCount != ReleaseCount) begin
      resetCount <= resetCount + 1'b1;
    end
  end

  assign systemReady = (resetCount == ReleaseCount);

endmodule

// ==== hdl/profilePkg.sv ====
package profilePkg;

  localparam int DataWidth = 32;
  localparam int IdWidth = 8;

  localparam int NumCounters = 4;
  localparam int CounterBaseId = 11; // Slot i answers CounterBaseId + i.

  localparam int ResetCycles = 16;
  localparam int ResetCountWidth = $clog2(ResetCycles + 1);

  // Command bits carried in valueA.
  localparam int CmdEnableBit = 0;
  localparam int CmdDisableBit = 1;
  localparam int CmdClearBit = 2;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] valueA;
    logic [DataWidth-1:0] valueB;
  } ciRequest_t;

  typedef struct packed {
    logic                 done;
    logic [DataWidth-1:0] result;
  } ciResponse_t;

  // Slot i counts bit i, so dCacheMiss goes to slot 0.
  typedef struct packed {
    logic stall;
    logic busIdle;
    logic iCacheMiss;
    logic dCacheMiss;
  } profileEvents_t;

endpackage
